// ==== rtl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Bus ranges.
`define DATA_BUS      31:0
`define INST_DATA_BUS 31:0
`define INST_ADDR_BUS 31:0

`define RESET_PC 32'h8000_0000

// Fixed SYSTEM encodings.
`define INST_ECALL 32'h0000_0073
`define INST_MRET  32'h3020_0073

`endif

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    // OP and OP-IMM funct3; F3_SR covers both right shifts.
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } op_f3_e;

    typedef enum logic [2:0] {
        F3_PRIV  = 3'b000, // ecall, mret.
        F3_CSRRW = 3'b001,
        F3_CSRRS = 3'b010
    } sys_f3_e;

endpackage

// ==== rtl/alu_pkg.sv ====
package alu_pkg;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10, // LUI.
        OR_B   = 4'd11  // CSR write operand.
    } alu_op_e;

endpackage

// ==== rtl/alu.sv ====
`include "core_settings.svh"

module alu (
    input  logic [`DATA_BUS]  a,
    input  logic [`DATA_BUS]  b,
    input  alu_pkg::alu_op_e  ctrl,
    output logic [`DATA_BUS]  result,
    output logic              zero_flag,
    output logic              less_flag
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Unsigned compare only for SLTU, signed otherwise.
    assign less_flag = (ctrl == alu_pkg::SLTU) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (ctrl)
            alu_pkg::ADD:    result = a + b;
            alu_pkg::SUB:    result = a - b;
            alu_pkg::SLL:    result = a << shamt;
            alu_pkg::SLT,
            alu_pkg::SLTU:   result = 32'(less_flag);
            alu_pkg::XOR:    result = a ^ b;
            alu_pkg::SRL:    result = a >> shamt;
            alu_pkg::SRA:    result = $signed(a) >>> shamt;
            alu_pkg::OR,
            alu_pkg::OR_B:   result = a | b;
            alu_pkg::AND:    result = a & b;
            alu_pkg::PASS_B: result = b;
            default:         result = a + b;
        endcase
    end

    assign zero_flag = (result == '0);

    // Codes above OR_B have no operation behind them.
    always_comb begin
        assert final ($isunknown(ctrl) || ctrl <= alu_pkg::OR_B)
            else $error("alu: undefined operation code %h", ctrl);
    end

endmodule

// ==== rtl/regfile.sv ====
`include "core_settings.svh"

module regfile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1_addr,
    input  logic [4:0]       rs2_addr,
    input  logic [4:0]       rd_addr,
    input  logic             rd_we,
    input  logic [`DATA_BUS] rd_wdata,
    output logic [`DATA_BUS] rs1_data,
    output logic [`DATA_BUS] rs2_data
);
    logic [`DATA_BUS] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/idu.sv ====
`include "core_settings.svh"

module idu (
    input  logic [`INST_DATA_BUS] inst,
    output logic [4:0]            rs1_addr,
    output logic [4:0]            rs2_addr,
    output logic [4:0]            rd_addr,
    output logic [`DATA_BUS]      imm,
    output alu_pkg::alu_op_e      alu_ctrl,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  adder_src_is_rs1,
    output logic                  rd_we,
    output logic                  wb_from_pc4,
    output logic                  wb_from_csr,
    output logic                  csr_we,
    output logic                  csr_set,
    output logic [11:0]           csr_addr
);
    rv_isa_pkg::opcode_e    opcode;
    rv_isa_pkg::branch_f3_e br_f3;
    rv_isa_pkg::sys_f3_e    sys_f3;
    logic [`DATA_BUS]       imm_i;
    logic [`DATA_BUS]       imm_b;
    logic [`DATA_BUS]       imm_u;
    logic [`DATA_BUS]       imm_j;

    // alt selects SUB or SRA.
    function automatic alu_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_pkg::alu_op_e op;
        case (rv_isa_pkg::op_f3_e'(f3))
            rv_isa_pkg::F3_ADD:  op = alt ? alu_pkg::SUB : alu_pkg::ADD;
            rv_isa_pkg::F3_SLL:  op = alu_pkg::SLL;
            rv_isa_pkg::F3_SLT:  op = alu_pkg::SLT;
            rv_isa_pkg::F3_SLTU: op = alu_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  op = alu_pkg::XOR;
            rv_isa_pkg::F3_SR:   op = alt ? alu_pkg::SRA : alu_pkg::SRL;
            rv_isa_pkg::F3_OR:   op = alu_pkg::OR;
            default:             op = alu_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode   = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign br_f3    = rv_isa_pkg::branch_f3_e'(inst[14:12]);
    assign sys_f3   = rv_isa_pkg::sys_f3_e'(inst[14:12]);
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];
    assign csr_addr = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm              = imm_i;
        alu_ctrl         = alu_pkg::ADD;
        src1_is_pc       = 1'b0;
        src2_is_imm      = 1'b0;
        adder_src_is_rs1 = 1'b0;
        rd_we            = 1'b0;
        wb_from_pc4      = 1'b0;
        wb_from_csr      = 1'b0;
        csr_we           = 1'b0;
        csr_set          = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                rd_we    = 1'b1;
                alu_ctrl = arith_op(inst[14:12], inst[30]);
            end
            rv_isa_pkg::OP_IMM: begin
                rd_we       = 1'b1;
                src2_is_imm = 1'b1;
                // No SUBI, so bit 30 only matters for right shifts.
                alu_ctrl    = arith_op(inst[14:12], inst[30] && inst[14:12] == 3'b101);
            end
            rv_isa_pkg::LUI: begin
                rd_we       = 1'b1;
                imm         = imm_u;
                src2_is_imm = 1'b1;
                alu_ctrl    = alu_pkg::PASS_B;
            end
            rv_isa_pkg::AUIPC: begin
                rd_we       = 1'b1;
                imm         = imm_u;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                rd_we       = 1'b1;
                imm         = imm_j;
                wb_from_pc4 = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                rd_we            = 1'b1;
                wb_from_pc4      = 1'b1;
                adder_src_is_rs1 = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                imm = imm_b;
                case (br_f3)
                    rv_isa_pkg::BEQ,
                    rv_isa_pkg::BNE:  alu_ctrl = alu_pkg::SUB;
                    rv_isa_pkg::BLT,
                    rv_isa_pkg::BGE:  alu_ctrl = alu_pkg::SLT;
                    default:          alu_ctrl = alu_pkg::SLTU;
                endcase
            end
            rv_isa_pkg::SYSTEM: begin
                // rs1 | 0 goes through the ALU as the CSR write value.
                if (sys_f3 == rv_isa_pkg::F3_CSRRW || sys_f3 == rv_isa_pkg::F3_CSRRS) begin
                    rd_we       = 1'b1;
                    wb_from_csr = 1'b1;
                    csr_we      = 1'b1;
                    csr_set     = (sys_f3 == rv_isa_pkg::F3_CSRRS);
                    imm         = '0;
                    src2_is_imm = 1'b1;
                    alu_ctrl    = alu_pkg::OR_B;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/exu.sv ====
`include "core_settings.svh"

module exu (
    input  logic [`INST_DATA_BUS] inst,
    input  logic [`DATA_BUS]      alu_src1,
    input  logic [`DATA_BUS]      alu_src2,
    input  alu_pkg::alu_op_e      alu_ctrl,
    input  logic [`DATA_BUS]      imm,
    input  logic [`DATA_BUS]      pc_adder_src2,
    input  logic [`DATA_BUS]      csr_rdata,
    output logic [`DATA_BUS]      alu_result,
    output logic [`INST_ADDR_BUS] dnpc
);
    rv_isa_pkg::opcode_e    opcode;
    rv_isa_pkg::branch_f3_e funct3;
    logic [`DATA_BUS]       pc_incr;
    logic [`INST_ADDR_BUS]  pc_sum;
    logic                   zero_flag;
    logic                   less_flag;
    logic                   trap_or_ret;

    assign opcode      = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3      = rv_isa_pkg::branch_f3_e'(inst[14:12]);
    assign trap_or_ret = (inst == `INST_ECALL) || (inst == `INST_MRET);

    always_comb begin
        case (opcode)
            rv_isa_pkg::JAL,
            rv_isa_pkg::JALR: pc_incr = imm;
            rv_isa_pkg::BRANCH: begin
                case (funct3)
                    rv_isa_pkg::BEQ:  pc_incr = zero_flag ? imm : 32'h4;
                    rv_isa_pkg::BNE:  pc_incr = zero_flag ? 32'h4 : imm;
                    rv_isa_pkg::BLT,
                    rv_isa_pkg::BLTU: pc_incr = less_flag ? imm : 32'h4;
                    rv_isa_pkg::BGE,
                    rv_isa_pkg::BGEU: pc_incr = less_flag ? 32'h4 : imm;
                    default:          pc_incr = 32'h4;
                endcase
            end
            default: pc_incr = 32'h4;
        endcase
    end

    assign pc_sum = pc_incr + pc_adder_src2; // Source 2 is pc, or rs1 for JALR.

    assign dnpc = trap_or_ret                    ? csr_rdata :
                  (opcode == rv_isa_pkg::JALR)   ? (pc_sum & ~32'h1) :
                                                   pc_sum;

    alu alu_inst (
        .a         (alu_src1),
        .b         (alu_src2),
        .ctrl      (alu_ctrl),
        .result    (alu_result),
        .zero_flag (zero_flag),
        .less_flag (less_flag)
    );

    always_comb begin
        assert final ($isunknown({inst, dnpc}) || dnpc[1:0] == 2'b00)
            else $error("exu: next pc %h is not word aligned", dnpc);
    end

endmodule

// ==== rtl/csr_unit.sv ====
`include "core_settings.svh"

module csr_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INST_DATA_BUS] inst,
    input  logic [`INST_ADDR_BUS] pc,
    input  logic [11:0]           csr_addr,
    input  logic                  csr_we,
    input  logic                  csr_set,
    input  logic [`DATA_BUS]      wdata,
    output logic [`DATA_BUS]      rdata
);
    localparam logic [11:0]      MTVEC_ADDR  = 12'h305;
    localparam logic [11:0]      MEPC_ADDR   = 12'h341;
    localparam logic [11:0]      MCAUSE_ADDR = 12'h342;
    localparam logic [`DATA_BUS] CAUSE_ECALL = 32'd11; // Environment call from M-mode.

    logic [`DATA_BUS] mtvec;
    logic [`DATA_BUS] mepc;
    logic [`DATA_BUS] mcause;
    logic [`DATA_BUS] csr_old;
    logic [`DATA_BUS] csr_new;
    logic             is_ecall;
    logic             is_mret;

    assign is_ecall = (inst == `INST_ECALL);
    assign is_mret  = (inst == `INST_MRET);

    always_comb begin
        case (csr_addr)
            MTVEC_ADDR:  csr_old = mtvec;
            MEPC_ADDR:   csr_old = mepc;
            MCAUSE_ADDR: csr_old = mcause;
            default:     csr_old = '0;
        endcase
    end

    assign csr_new = csr_set ? (csr_old | wdata) : wdata;
    assign rdata   = is_ecall ? mtvec : (is_mret ? mepc : csr_old);

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else if (is_ecall) begin
            mepc   <= pc;
            mcause <= CAUSE_ECALL;
        end else if (csr_we) begin
            case (csr_addr)
                MTVEC_ADDR:  mtvec  <= csr_new;
                MEPC_ADDR:   mepc   <= csr_new;
                MCAUSE_ADDR: mcause <= csr_new;
                default: ;
            endcase
        end
    end

    // The trap save would silently drop a CSR write in the same cycle.
    assert property (@(posedge clk) disable iff (rst) !(is_ecall && csr_we))
        else $error("csr_unit: CSR write requested together with ecall");

endmodule

// ==== rtl/rv_core.sv ====
`include "core_settings.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INST_DATA_BUS] inst,
    output logic [`INST_ADDR_BUS] pc,
    output logic                  wb_en,
    output logic [4:0]            wb_addr,
    output logic [`DATA_BUS]      wb_data
);
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [`DATA_BUS]      imm;
    alu_pkg::alu_op_e      alu_ctrl;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  adder_src_is_rs1;
    logic                  wb_from_pc4;
    logic                  wb_from_csr;
    logic                  csr_we;
    logic                  csr_set;
    logic [11:0]           csr_addr;
    logic [`DATA_BUS]      rs1_data;
    logic [`DATA_BUS]      rs2_data;
    logic [`DATA_BUS]      alu_src1;
    logic [`DATA_BUS]      alu_src2;
    logic [`DATA_BUS]      pc_adder_src2;
    logic [`DATA_BUS]      alu_result;
    logic [`DATA_BUS]      csr_rdata;
    logic [`INST_ADDR_BUS] dnpc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

    assign alu_src1      = src1_is_pc ? pc : rs1_data;
    assign alu_src2      = src2_is_imm ? imm : rs2_data;
    assign pc_adder_src2 = adder_src_is_rs1 ? rs1_data : pc;

    // Links take pc + 4; CSR ops return the old value.
    assign wb_data = wb_from_csr ? csr_rdata :
                     wb_from_pc4 ? (pc + 32'd4) :
                                   alu_result;

    idu idu_inst (
        .inst             (inst),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .rd_addr          (wb_addr),
        .imm              (imm),
        .alu_ctrl         (alu_ctrl),
        .src1_is_pc       (src1_is_pc),
        .src2_is_imm      (src2_is_imm),
        .adder_src_is_rs1 (adder_src_is_rs1),
        .rd_we            (wb_en),
        .wb_from_pc4      (wb_from_pc4),
        .wb_from_csr      (wb_from_csr),
        .csr_we           (csr_we),
        .csr_set          (csr_set),
        .csr_addr         (csr_addr)
    );

    regfile regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (wb_addr),
        .rd_we    (wb_en),
        .rd_wdata (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exu exu_inst (
        .inst          (inst),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .alu_ctrl      (alu_ctrl),
        .imm           (imm),
        .pc_adder_src2 (pc_adder_src2),
        .csr_rdata     (csr_rdata),
        .alu_result    (alu_result),
        .dnpc          (dnpc)
    );

    csr_unit csr_unit_inst (
        .clk      (clk),
        .rst      (rst),
        .inst     (inst),
        .pc       (pc),
        .csr_addr (csr_addr),
        .csr_we   (csr_we),
        .csr_set  (csr_set),
        .wdata    (alu_result),
        .rdata    (csr_rdata)
    );

endmodule

// ==== tb/tb_rv_core.sv ====
`include "core_settings.svh"

module tb_rv_core;

    localparam logic [`INST_DATA_BUS] NOP = 32'h0000_0013; // addi x0, x0, 0.

    logic                  clk;
    logic                  rst;
    logic [`INST_DATA_BUS] inst;
    logic [`INST_ADDR_BUS] pc;
    logic                  wb_en;
    logic [4:0]            wb_addr;
    logic [`DATA_BUS]      wb_data;

    logic [`INST_DATA_BUS] test_inst [$];
    logic                  test_en   [$];
    logic [4:0]            test_addr [$];
    logic [`DATA_BUS]      test_data [$];
    logic [`INST_ADDR_BUS] test_npc  [$];

    int step;
    int error_count;
    int cycle_count;
    int cycle_limit;

    rv_core rv_core_inst (
        .clk     (clk),
        .rst     (rst),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at step %0d.", step);
    endtask

    task automatic check_wb(input logic exp_en, input logic [4:0] exp_addr,
                            input logic [`DATA_BUS] exp_data);
        if (wb_en !== exp_en) begin
            $display("[ERROR] wb_en: expected %h, got %h (step %0d)", exp_en, wb_en, step);
            abort_run();
        end else if (exp_en && wb_addr !== exp_addr) begin
            $display("[ERROR] wb_addr: expected %h, got %h (step %0d)", exp_addr, wb_addr, step);
            abort_run();
        end else if (exp_en && wb_data !== exp_data) begin
            $display("[ERROR] wb_data: expected %h, got %h (step %0d)", exp_data, wb_data, step);
            abort_run();
        end
    endtask

    task automatic check_pc(input logic [`INST_ADDR_BUS] exp_pc);
        if (pc !== exp_pc) begin
            $display("[ERROR] pc: expected %h, got %h (step %0d)", exp_pc, pc, step);
            abort_run();
        end
    endtask

    // Lines starting with # are comments.
    task automatic load_tests();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_inst;
        logic [31:0] f_en;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_npc;
        fd = $fopen("tb/core_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file tb/core_tests.txt.");
            abort_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%h %h %h %h %h",
                                    f_inst, f_en, f_addr, f_data, f_npc);
                    if (count != 5) begin
                        $display("Test file has a line without five fields: %s", line);
                        abort_run();
                    end else begin
                        test_inst.push_back(f_inst);
                        test_en.push_back(f_en[0]);
                        test_addr.push_back(f_addr[4:0]);
                        test_data.push_back(f_data);
                        test_npc.push_back(f_npc);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles.", cycle_limit);
            abort_run();
        end
    end

    initial begin
        rst         = 1'b1;
        inst        = NOP;
        step        = 0;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_tests();
        if (test_inst.size() == 0) begin
            $display("The test file holds no test lines.");
            abort_run();
        end
        cycle_limit = test_inst.size() * 2 + 20;

        repeat (4) @(posedge clk);
        rst  <= 1'b0;
        inst <= test_inst[0];

        // Write-back is checked mid-cycle, the pc after each edge.
        for (int i = 0; i < test_inst.size(); i++) begin
            step = i;
            @(negedge clk);
            if (i == 0) begin
                check_pc(`RESET_PC);
            end else begin
                check_pc(test_npc[i - 1]);
            end
            check_wb(test_en[i], test_addr[i], test_data[i]);
            @(posedge clk);
            if (i + 1 < test_inst.size()) begin
                inst <= test_inst[i + 1];
            end else begin
                inst <= NOP;
            end
        end
        @(negedge clk);
        check_pc(test_npc[test_inst.size() - 1]);

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/alu_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/idu.sv
rtl/exu.sv
rtl/csr_unit.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output."
exit 1

// ==== tb/core_tests.txt ====
# Columns, all hex: inst, wb_en, wb_addr, wb_data, next pc.
# wb_addr and wb_data are only checked when wb_en is 1.
00500093 1 01 00000005 80000004
FFD00113 1 02 FFFFFFFD 80000008
123451B7 1 03 12345000 8000000C
00208233 1 04 00000002 80000010
402082B3 1 05 00000008 80000014
40115333 1 06 FFFFFFFF 80000018
0020B3B3 1 07 00000001 8000001C
0020A433 1 08 00000000 80000020
00708013 1 00 0000000C 80000024
000004B3 1 09 00000000 80000028
00108463 0 00 00000000 80000030
00109463 0 00 00000000 80000034
00114463 0 00 00000000 8000003C
00116463 0 00 00000000 80000040
FE20D8E3 0 00 00000000 80000030
0020F463 0 00 00000000 80000034
00208463 0 00 00000000 80000038
00209463 0 00 00000000 80000040
0020C463 0 00 00000000 80000044
0020E463 0 00 00000000 8000004C
00115463 0 00 00000000 80000050
00117463 0 00 00000000 80000058
0100056F 1 0A 8000005C 80000068
00000617 1 0C 80000068 8000006C
00D605E7 1 0B 80000070 80000074
800016B7 1 0D 80001000 80000078
30569773 1 0E 00000000 8000007C
3052A7F3 1 0F 80001000 80000080
30502873 1 10 80001008 80000084
00000073 0 00 00000000 80001008
341028F3 1 11 80000084 8000100C
30200073 0 00 00000000 80000084
34202973 1 12 0000000B 80000088
